/* zports_defines.svh */
`ifndef ZPORTS_DEFINES_SVH
`define ZPORTS_DEFINES_SVH

// bus widths
`define ZP_ABUS_W 16
`define ZP_DBUS_W 8

// low address byte of each decoded port
`define ZP_PORT_FE    8'hFE
`define ZP_PORT_FD    8'hFD
`define ZP_PORT_F7    8'hF7
`define ZP_PORT_BF    8'hBF
`define ZP_PORT_KJOY  8'h1F
`define ZP_PORT_MOUSE 8'hDF
`define ZP_PORT_CVX1  8'hFB
`define ZP_PORT_CVX2  8'hDD
`define ZP_PORT_SD0   8'h0F
`define ZP_PORT_SD1   8'h1F
`define ZP_PORT_SD2   8'h4F
`define ZP_PORT_SD3   8'h5F

// ide task file, nemo layout
`define ZP_IDE_10 8'h10
`define ZP_IDE_11 8'h11
`define ZP_IDE_30 8'h30
`define ZP_IDE_50 8'h50
`define ZP_IDE_70 8'h70
`define ZP_IDE_90 8'h90
`define ZP_IDE_B0 8'hB0
`define ZP_IDE_D0 8'hD0
`define ZP_IDE_F0 8'hF0
`define ZP_IDE_C8 8'hC8

`define ZP_IDLE_DATA 8'hFF // nothing drives the bus

// upper address fields
`define ZP_AY_HI   15
`define ZP_AY_LO   14
`define ZP_AY_REG  2'b11 // FFFD
`define ZP_AY_DAT  2'b10 // BFFD
`define ZP_A_7FFD  15
`define ZP_A_EFF7  12

// reset values
`define ZP_P7FFD_RST  8'h00
`define ZP_PEFF7_RST  8'h00
`define ZP_BORDER_RST 6'h00
`define ZP_PSD_RST    8'h00

`endif

/* zports_pkg.sv */
package zports_pkg;

	// decoded target of the current io address
	typedef enum logic [3:0]
	{
		SEL_NONE     = 4'd0,
		SEL_FE       = 4'd1,  // keyboard, border, beeper
		SEL_FD       = 4'd2,  // 7FFD paging and the AY ports
		SEL_F7       = 4'd3,  // EFF7, hidden in shadow
		SEL_BF       = 4'd4,  // shadow and rom write enable
		SEL_KJOY     = 4'd5,  // kempston joystick, also soundrive ch 1
		SEL_MOUSE    = 4'd6,
		SEL_COVOX    = 4'd7,
		SEL_SDRIVE   = 4'd8,
		SEL_IDE_EVEN = 4'd9,  // every ide port except #11
		SEL_IDE_ODD  = 4'd10  // #11, high data byte
	} port_sel_t;

	// kind of ide access on the bus
	typedef enum logic [1:0]
	{
		IDE_NONE    = 2'd0,
		IDE_DATA_LO = 2'd1, // #10
		IDE_DATA_HI = 2'd2, // #11
		IDE_REG     = 2'd3  // remaining task file ports
	} ide_acc_t;

endpackage

/* port_strobe.sv */
`timescale 1ns/1ns

module port_strobe (
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_rd,
	output logic port_wr
);

	logic io_rd;   // iorq and rd both low
	logic io_wr;
	logic io_rd_q; // level seen on the previous edge
	logic io_wr_q;

	assign io_rd = ~(iorq_n | rd_n);
	assign io_wr = ~(iorq_n | wr_n);

	// one pulse at the leading edge of each bus cycle
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_rd_q <= 1'b0;
			io_wr_q <= 1'b0;
			port_rd <= 1'b0;
			port_wr <= 1'b0;
		end
		else
		begin
			io_rd_q <= io_rd;
			io_wr_q <= io_wr;
			port_rd <= io_rd & ~io_rd_q;
			port_wr <= io_wr & ~io_wr_q;
		end
	end

endmodule

/* port_decode.sv */
`timescale 1ns/1ns
`include "zports_defines.svh"

module port_decode (
	input  logic [`ZP_ABUS_W-1:0] a,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  shadow,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic [4:0]            kj_in,
	input  logic [7:0]            mus_in,
	input  logic [7:0]            ide_rdata,
	output zports_pkg::port_sel_t sel,
	output zports_pkg::ide_acc_t  ide_acc,
	output logic                  porthit,
	output logic                  dataout,
	output logic [`ZP_DBUS_W-1:0] dout,
	output logic                  ay_bc1,
	output logic                  ay_bdir
);

	logic [7:0] loa;
	logic [1:0] ay_fld;
	logic       ext_port; // FFFD read is answered by the AY chip
	logic       pre_bc1;
	logic       pre_bdir;

	assign loa    = a[7:0];
	assign ay_fld = a[`ZP_AY_HI:`ZP_AY_LO];

	//////////////////////////////////////////////////////////////////////
	// target select

	always_comb
	begin
		case (loa)
			`ZP_PORT_FE:    sel = zports_pkg::SEL_FE;
			`ZP_PORT_FD:    sel = zports_pkg::SEL_FD;
			`ZP_PORT_F7:    sel = shadow ? zports_pkg::SEL_NONE : zports_pkg::SEL_F7;
			`ZP_PORT_BF:    sel = zports_pkg::SEL_BF;
			`ZP_PORT_KJOY:  sel = shadow ? zports_pkg::SEL_NONE : zports_pkg::SEL_KJOY;
			`ZP_PORT_MOUSE: sel = zports_pkg::SEL_MOUSE;
			`ZP_PORT_CVX1,
			`ZP_PORT_CVX2:  sel = zports_pkg::SEL_COVOX;
			`ZP_PORT_SD0,
			`ZP_PORT_SD2,
			`ZP_PORT_SD3:   sel = shadow ? zports_pkg::SEL_NONE : zports_pkg::SEL_SDRIVE;
			`ZP_IDE_10, `ZP_IDE_30, `ZP_IDE_50, `ZP_IDE_70, `ZP_IDE_90,
			`ZP_IDE_B0, `ZP_IDE_D0, `ZP_IDE_F0, `ZP_IDE_C8:
				sel = zports_pkg::SEL_IDE_EVEN;
			`ZP_IDE_11:     sel = zports_pkg::SEL_IDE_ODD;
			default:        sel = zports_pkg::SEL_NONE;
		endcase
	end

	always_comb
	begin
		case (loa)
			`ZP_IDE_10: ide_acc = zports_pkg::IDE_DATA_LO;
			`ZP_IDE_11: ide_acc = zports_pkg::IDE_DATA_HI;
			`ZP_IDE_30, `ZP_IDE_50, `ZP_IDE_70, `ZP_IDE_90,
			`ZP_IDE_B0, `ZP_IDE_D0, `ZP_IDE_F0, `ZP_IDE_C8:
				ide_acc = zports_pkg::IDE_REG;
			default:    ide_acc = zports_pkg::IDE_NONE;
		endcase
	end

	assign porthit  = (sel != zports_pkg::SEL_NONE);
	assign ext_port = (loa == `ZP_PORT_FD) && (ay_fld == `ZP_AY_REG);
	assign dataout  = porthit & ~iorq_n & ~rd_n & ~ext_port;

	//////////////////////////////////////////////////////////////////////
	// read data

	always_comb
	begin
		case (sel)
			zports_pkg::SEL_FE:       dout = {1'b1, tape_read, 1'b0, keys_in};
			zports_pkg::SEL_KJOY:     dout = {3'b000, kj_in};
			zports_pkg::SEL_MOUSE:    dout = mus_in;
			zports_pkg::SEL_IDE_EVEN,
			zports_pkg::SEL_IDE_ODD:  dout = ide_rdata;
			default:                  dout = `ZP_IDLE_DATA;
		endcase
	end

	// AY register select and data, FFFD and BFFD
	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (loa == `ZP_PORT_FD)
		begin
			if (ay_fld == `ZP_AY_REG)
			begin
				pre_bc1  = 1'b1;
				pre_bdir = 1'b1;
			end
			else if (ay_fld == `ZP_AY_DAT)
				pre_bdir = 1'b1;
		end
	end

	assign ay_bc1  = pre_bc1 & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = pre_bdir & ~iorq_n & ~wr_n;

endmodule

/* mem_config_regs.sv */
`timescale 1ns/1ns
`include "zports_defines.svh"

module mem_config_regs (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zports_pkg::port_sel_t sel,
	input  logic                  port_wr,
	input  logic [`ZP_ABUS_W-1:0] a,
	input  logic [`ZP_DBUS_W-1:0] din,
	input  logic [1:0]            rstrom,
	input  logic                  dos,
	output logic                  shadow,
	output logic                  romrw_en,
	output logic [7:0]            p7ffd,
	output logic [7:0]            peff7,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output logic [5:0]            pent1m_page
);

	logic [7:0] p7ffd_r;
	logic       p7ffd_rom; // rom select as seen on p7ffd
	logic [7:0] peff7_r;
	logic       shadow_en;
	logic       block1m;   // eff7 bit 2
	logic       block7ffd;
	logic       wr_7ffd;
	logic       wr_eff7;

	assign block1m   = peff7_r[2];
	assign block7ffd = p7ffd_r[5] & block1m; // 48k lock only with 1m off
	assign wr_7ffd   = port_wr && (sel == zports_pkg::SEL_FD) && !a[`ZP_A_7FFD] && !block7ffd;
	assign wr_eff7   = port_wr && (sel == zports_pkg::SEL_F7) && !a[`ZP_A_EFF7];

	//////////////////////////////////////////////////////////////////////
	// 7FFD, EFF7, xxBF

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r   <= `ZP_P7FFD_RST;
			p7ffd_rom <= rstrom[0]; // boot rom choice
			peff7_r   <= `ZP_PEFF7_RST;
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
		end
		else
		begin
			if (wr_7ffd)
			begin
				p7ffd_r   <= din; // 2..0 page, 3 screen, 4 rom, 5 block48k
				p7ffd_rom <= din[4];
			end
			if (wr_eff7)
				peff7_r <= din;
			if (port_wr && (sel == zports_pkg::SEL_BF))
			begin
				shadow_en <= din[0];
				romrw_en  <= din[1];
			end
		end
	end

	assign shadow = dos | shadow_en;

	// 1m mode masks the extended page bits
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_r[7:5]), p7ffd_rom, p7ffd_r[3:0]};
	assign peff7 = block1m ? {peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]} : peff7_r;

	assign pent1m_rom    = p7ffd_r[4];
	assign pent1m_page   = {p7ffd_r[7:5], p7ffd_r[2:0]};
	assign pent1m_1m_on  = ~peff7_r[2];
	assign pent1m_ram0_0 = peff7_r[3];

endmodule

/* sound_border.sv */
`timescale 1ns/1ns
`include "zports_defines.svh"

module sound_border (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zports_pkg::port_sel_t sel,
	input  logic                  port_wr,
	input  logic [7:0]            a_lo,
	input  logic [`ZP_DBUS_W-1:0] din,
	output logic [5:0]            border,
	output logic [7:0]            psd0,
	output logic [7:0]            psd1,
	output logic [7:0]            psd2,
	output logic [7:0]            psd3
);

	logic fe_wr;
	logic cvx_wr;
	logic sd_wr;

	assign fe_wr  = port_wr && (sel == zports_pkg::SEL_FE);
	assign cvx_wr = port_wr && (sel == zports_pkg::SEL_COVOX);
	// channel 1 shares 1F with the joystick
	assign sd_wr  = port_wr && ((sel == zports_pkg::SEL_SDRIVE) || (sel == zports_pkg::SEL_KJOY));

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= `ZP_BORDER_RST;
			psd0   <= `ZP_PSD_RST;
			psd1   <= `ZP_PSD_RST;
			psd2   <= `ZP_PSD_RST;
			psd3   <= `ZP_PSD_RST;
		end
		else if (fe_wr)
		begin
			border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};
			psd0   <= {8{din[4]}}; // beeper on the left pair
			psd1   <= {8{din[4]}};
			psd2   <= {din[4], {7{din[3]}}};
			psd3   <= {8{din[3]}}; // tape out
		end
		else if (cvx_wr)
		begin
			psd0 <= din;
			psd1 <= din;
			psd2 <= din;
			psd3 <= din;
		end
		else if (sd_wr)
		begin
			case (a_lo)
				`ZP_PORT_SD0: psd0 <= din;
				`ZP_PORT_SD1: psd1 <= din;
				`ZP_PORT_SD2: psd2 <= din;
				`ZP_PORT_SD3: psd3 <= din;
				default:      psd0 <= psd0;
			endcase
		end
	end

endmodule

/* ide_bridge.sv */
`timescale 1ns/1ns
`include "zports_defines.svh"

module ide_bridge (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zports_pkg::ide_acc_t  ide_acc,
	input  logic                  port_rd,
	input  logic                  port_wr,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [2:0]            a_hi3,
	input  logic                  cs1_sel,
	input  logic [`ZP_DBUS_W-1:0] din,
	input  logic [15:0]           idein,
	output logic [15:0]           ideout,
	output logic [7:0]            ide_rdata,
	output logic [2:0]            ide_a,
	output logic                  ide_cs0_n,
	output logic                  ide_cs1_n,
	output logic                  ide_rd_n,
	output logic                  ide_wr_n,
	output logic                  idedataout
);

	logic        acc_lo;    // #10
	logic        acc_hi;    // #11
	logic        dev_port;  // ports wired to the drive
	logic        any_ide;
	logic        lo_rd;     // first half of a word read

	logic        rd_trig;   // nemo-divide triggers
	logic        wrlo_trig;
	logic        wrhi_trig;
	logic        rd_hold;   // trigger state frozen for the bus cycle
	logic        wrlo_hold;
	logic        wrhi_hold;

	logic [7:0]  hi_in;     // high byte kept from the low read
	logic [15:0] wr_stage;  // byte written ahead of the strobe

	assign acc_lo   = (ide_acc == zports_pkg::IDE_DATA_LO);
	assign acc_hi   = (ide_acc == zports_pkg::IDE_DATA_HI);
	assign dev_port = acc_lo || (ide_acc == zports_pkg::IDE_REG);
	assign any_ide  = (ide_acc != zports_pkg::IDE_NONE);
	assign lo_rd    = port_rd && acc_lo && !rd_trig;

	//////////////////////////////////////////////////////////////////////
	// triggers
	// normal read  #10 lo, #11 hi     divide read  #10 lo, #10 hi
	// normal write #11 hi, #10 lo     divide write #10 lo, #10 hi

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_trig   <= 1'b0;
			wrlo_trig <= 1'b0;
			wrhi_trig <= 1'b0;
		end
		else
		begin
			if (lo_rd)
				rd_trig <= 1'b1;
			else if (any_ide && (port_rd || port_wr))
				rd_trig <= 1'b0;

			if (any_ide && (port_rd || port_wr))
			begin
				wrhi_trig <= acc_hi && port_wr;
				wrlo_trig <= acc_lo && port_wr && !wrhi_trig && !wrlo_trig;
			end
		end
	end

	// sampled only while the strobe is high so the cycle sees a stable value
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_hold   <= 1'b0;
			wrlo_hold <= 1'b0;
			wrhi_hold <= 1'b0;
		end
		else
		begin
			if (rd_n)
				rd_hold <= rd_trig;
			if (wr_n)
			begin
				wrlo_hold <= wrlo_trig;
				wrhi_hold <= wrhi_trig;
			end
		end
	end

	// data staging
	always_ff @(posedge zclk)
	begin
		if (lo_rd)
			hi_in <= idein[15:8];
		if (port_wr && acc_hi)
			wr_stage[15:8] <= din;
		if (port_wr && acc_lo && !wrlo_trig)
			wr_stage[7:0] <= din;
	end

	//////////////////////////////////////////////////////////////////////
	// drive side

	assign ide_a     = a_hi3;
	assign ide_cs0_n = ~dev_port | cs1_sel;
	assign ide_cs1_n = ~dev_port | ~cs1_sel;

	assign ide_rd_n   = iorq_n | rd_n | ~dev_port | (rd_hold && acc_lo); // divide hi read
	assign ide_wr_n   = iorq_n | wr_n | ~dev_port | (acc_lo && !wrlo_hold && !wrhi_hold);
	assign idedataout = ide_rd_n;

	assign ide_rdata = (acc_hi || (rd_hold && acc_lo)) ? hi_in : idein[7:0];

	assign ideout[15:8] = wrhi_hold ? wr_stage[15:8] : din;
	assign ideout[7:0]  = wrlo_hold ? wr_stage[7:0] : din;

endmodule

/* zports.sv */
`timescale 1ns/1ns
`include "zports_defines.svh"

module zports (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [`ZP_ABUS_W-1:0] a,
	input  logic [`ZP_DBUS_W-1:0] din,
	output logic [`ZP_DBUS_W-1:0] dout,
	output logic                  dataout,
	output logic                  porthit,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output logic [15:0]           ideout,
	input  logic [15:0]           idein,
	output logic                  idedataout,
	output logic [2:0]            ide_a,
	output logic                  ide_cs0_n,
	output logic                  ide_cs1_n,
	output logic                  ide_rd_n,
	output logic                  ide_wr_n,
	input  logic [4:0]            keys_in,
	input  logic [7:0]            mus_in,
	input  logic [4:0]            kj_in,
	input  logic                  tape_read,
	output logic [5:0]            border,
	output logic [7:0]            psd0,
	output logic [7:0]            psd1,
	output logic [7:0]            psd2,
	output logic [7:0]            psd3,
	output logic                  ay_bdir,
	output logic                  ay_bc1,
	input  logic                  dos,
	input  logic [1:0]            rstrom,
	output logic [7:0]            p7ffd,
	output logic [7:0]            peff7,
	output logic                  romrw_en,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output logic [5:0]            pent1m_page
);

	logic                  port_rd;
	logic                  port_wr;
	logic                  shadow;
	logic [7:0]            ide_rdata;
	zports_pkg::port_sel_t sel;
	zports_pkg::ide_acc_t  ide_acc;
	wire                   cs1_sel = (a[7:0] == `ZP_IDE_C8);

	port_strobe i_strobe (
		.zclk(zclk), .rst_n(rst_n),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.port_rd(port_rd), .port_wr(port_wr)
	);

	port_decode i_decode (
		.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .shadow(shadow),
		.keys_in(keys_in), .tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in),
		.ide_rdata(ide_rdata), .sel(sel), .ide_acc(ide_acc),
		.porthit(porthit), .dataout(dataout), .dout(dout),
		.ay_bc1(ay_bc1), .ay_bdir(ay_bdir)
	);

	mem_config_regs i_mem_cfg (
		.zclk(zclk), .rst_n(rst_n), .sel(sel), .port_wr(port_wr),
		.a(a), .din(din), .rstrom(rstrom), .dos(dos),
		.shadow(shadow), .romrw_en(romrw_en), .p7ffd(p7ffd), .peff7(peff7),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0), .pent1m_page(pent1m_page)
	);

	sound_border i_sound (
		.zclk(zclk), .rst_n(rst_n), .sel(sel), .port_wr(port_wr),
		.a_lo(a[7:0]), .din(din), .border(border),
		.psd0(psd0), .psd1(psd1), .psd2(psd2), .psd3(psd3)
	);

	ide_bridge i_ide (
		.zclk(zclk), .rst_n(rst_n), .ide_acc(ide_acc),
		.port_rd(port_rd), .port_wr(port_wr),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a_hi3(a[7:5]), .cs1_sel(cs1_sel), .din(din), .idein(idein),
		.ideout(ideout), .ide_rdata(ide_rdata), .ide_a(ide_a),
		.ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n),
		.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n), .idedataout(idedataout)
	);

endmodule

/* tb_zports.sv */
`timescale 1ns/1ns
`include "zports_defines.svh"

module tb_zports;

	localparam int          CLK_PERIOD = 4;
	localparam int          RST_CYCLES = 5;
	localparam int          MAX_ENT    = 64;
	localparam logic [31:0] SEED       = 32'hb7f3_70aa;

	logic                  zclk;
	logic                  rst_n;
	logic [`ZP_ABUS_W-1:0] a;
	logic [`ZP_DBUS_W-1:0] din;
	logic [`ZP_DBUS_W-1:0] dout;
	logic                  dataout;
	logic                  porthit;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic [15:0]           ideout;
	logic [15:0]           idein;
	logic                  idedataout;
	logic [2:0]            ide_a;
	logic                  ide_cs0_n;
	logic                  ide_cs1_n;
	logic                  ide_rd_n;
	logic                  ide_wr_n;
	logic [4:0]            keys_in;
	logic [7:0]            mus_in;
	logic [4:0]            kj_in;
	logic                  tape_read;
	logic [5:0]            border;
	logic [7:0]            psd0;
	logic [7:0]            psd1;
	logic [7:0]            psd2;
	logic [7:0]            psd3;
	logic                  ay_bdir;
	logic                  ay_bc1;
	logic                  dos;
	logic [1:0]            rstrom;
	logic [7:0]            p7ffd;
	logic [7:0]            peff7;
	logic                  romrw_en;
	logic                  pent1m_rom;
	logic                  pent1m_1m_on;
	logic                  pent1m_ram0_0;
	logic [5:0]            pent1m_page;

	//////////////////////////////////////////////////////////////////////
	// stimulus table, one bus cycle per entry

	logic [15:0] t_addr    [MAX_ENT];
	logic        t_wr      [MAX_ENT];
	logic [7:0]  t_din     [MAX_ENT];
	logic        t_dos     [MAX_ENT];
	logic [15:0] t_idein   [MAX_ENT];
	logic [7:0]  t_dout    [MAX_ENT]; // read entries only
	logic        t_hit     [MAX_ENT];
	logic        t_dataout [MAX_ENT];
	logic        t_bc1     [MAX_ENT];
	logic        t_bdir    [MAX_ENT];
	logic        t_rd_n    [MAX_ENT];
	logic        t_wr_n    [MAX_ENT];
	logic [15:0] t_ideout  [MAX_ENT];
	logic        t_chk_io  [MAX_ENT];
	logic [2:0]  t_ide_a   [MAX_ENT];
	logic        t_cs0_n   [MAX_ENT];
	logic        t_cs1_n   [MAX_ENT];
	logic [7:0]  t_p7ffd   [MAX_ENT]; // register state after the cycle
	logic [7:0]  t_peff7   [MAX_ENT];
	logic [5:0]  t_border  [MAX_ENT];
	logic [31:0] t_psd     [MAX_ENT]; // psd3..psd0
	logic        t_romrw   [MAX_ENT];
	logic [8:0]  t_pent1m  [MAX_ENT]; // rom, 1m_on, ram0_0, page

	// expected register state while the table is built
	logic [7:0]  e_p7ffd;
	logic [7:0]  e_peff7;
	logic [5:0]  e_border;
	logic [31:0] e_psd;
	logic        e_romrw;
	logic [8:0]  e_pent1m;

	int          n_ent;
	int          n_err;
	int          n_checks;
	int          cur_ent;
	logic        table_done;
	int unsigned seed_v;

	zports i_zports (
		.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .dout(dout),
		.dataout(dataout), .porthit(porthit),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.ideout(ideout), .idein(idein), .idedataout(idedataout), .ide_a(ide_a),
		.ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n),
		.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n),
		.keys_in(keys_in), .mus_in(mus_in), .kj_in(kj_in), .tape_read(tape_read),
		.border(border), .psd0(psd0), .psd1(psd1), .psd2(psd2), .psd3(psd3),
		.ay_bdir(ay_bdir), .ay_bc1(ay_bc1), .dos(dos), .rstrom(rstrom),
		.p7ffd(p7ffd), .peff7(peff7), .romrw_en(romrw_en),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0), .pent1m_page(pent1m_page)
	);

	initial
	begin
		zclk = 1'b0;
		forever #(CLK_PERIOD/2) zclk = ~zclk;
	end

	function automatic logic [7:0] pick_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic logic [15:0] new_word();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	// task file ports wired to the drive, #11 only feeds the latch
	function automatic logic is_ide_device(input logic [7:0] lo);
		case (lo)
			`ZP_IDE_10, `ZP_IDE_30, `ZP_IDE_50, `ZP_IDE_70, `ZP_IDE_90,
			`ZP_IDE_B0, `ZP_IDE_D0, `ZP_IDE_F0, `ZP_IDE_C8:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_err++;
			$display("mismatch at %0t ns, entry %0d, %s: got %0h, expected %0h",
				$time, cur_ent, name, got, exp);
		end
	endtask

	task automatic add_entry(
		input logic [15:0] addr,
		input logic        is_wr,
		input logic [7:0]  data,
		input logic        dos_v,
		input logic [15:0] word,
		input logic [7:0]  exp_dout,
		input logic        exp_hit,
		input logic        exp_rd_n,
		input logic        exp_wr_n,
		input logic [15:0] exp_ideout,
		input logic        chk_ideout
	);
		logic [7:0] lo_b;

		lo_b             = addr[7:0];
		t_addr[n_ent]    = addr;
		t_wr[n_ent]      = is_wr;
		t_din[n_ent]     = data;
		t_dos[n_ent]     = dos_v;
		t_idein[n_ent]   = word;
		t_dout[n_ent]    = exp_dout;
		t_hit[n_ent]     = exp_hit;
		t_dataout[n_ent] = exp_hit & ~is_wr & (addr != 16'hFFFD); // AY answers FFFD
		t_bc1[n_ent]     = (addr == 16'hFFFD);
		t_bdir[n_ent]    = is_wr & ((addr == 16'hFFFD) | (addr == 16'hBFFD));
		t_rd_n[n_ent]    = exp_rd_n;
		t_wr_n[n_ent]    = exp_wr_n;
		t_ideout[n_ent]  = exp_ideout;
		t_chk_io[n_ent]  = chk_ideout;
		t_ide_a[n_ent]   = addr[7:5];
		if (!is_ide_device(lo_b))
		begin
			t_cs0_n[n_ent] = 1'b1;
			t_cs1_n[n_ent] = 1'b1;
		end
		else if (lo_b == `ZP_IDE_C8)
		begin
			t_cs0_n[n_ent] = 1'b1; // alternate status lives on cs1
			t_cs1_n[n_ent] = 1'b0;
		end
		else
		begin
			t_cs0_n[n_ent] = 1'b0;
			t_cs1_n[n_ent] = 1'b1;
		end
		t_p7ffd[n_ent]   = e_p7ffd;
		t_peff7[n_ent]   = e_peff7;
		t_border[n_ent]  = e_border;
		t_psd[n_ent]     = e_psd;
		t_romrw[n_ent]   = e_romrw;
		t_pent1m[n_ent]  = e_pent1m;
		n_ent++;
	endtask

	task automatic io_wr(input logic [15:0] addr, input logic [7:0] data, input logic hit);
		add_entry(addr, 1'b1, data, 1'b0, 16'h0000, `ZP_IDLE_DATA, hit, 1'b1, 1'b1,
			16'h0000, 1'b0);
	endtask

	task automatic io_rd(input logic [15:0] addr, input logic dos_v, input logic [7:0] exp,
		input logic hit);
		add_entry(addr, 1'b0, 8'h00, dos_v, 16'h0000, exp, hit, 1'b1, 1'b1, 16'h0000, 1'b0);
	endtask

	task automatic ide_rd(input logic [15:0] addr, input logic [15:0] word,
		input logic [7:0] exp, input logic exp_rd_n);
		add_entry(addr, 1'b0, 8'h00, 1'b0, word, exp, 1'b1, exp_rd_n, 1'b1, 16'h0000, 1'b0);
	endtask

	task automatic ide_wr(input logic [15:0] addr, input logic [7:0] data,
		input logic exp_wr_n, input logic [15:0] exp_word, input logic chk);
		add_entry(addr, 1'b1, data, 1'b0, 16'h0000, `ZP_IDLE_DATA, 1'b1, 1'b1, exp_wr_n,
			exp_word, chk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// table contents

	task automatic build_table();
		logic [7:0]  d;
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [15:0] w1;
		logic [15:0] w2;

		n_ent    = 0;
		e_peff7  = 8'h00;
		e_border = 6'h00;
		e_psd    = 32'h0;
		e_romrw  = 1'b0;
		e_pent1m = {1'b0, 1'b1, 1'b0, 6'h00};

		// paging
		e_p7ffd  = 8'hD3;
		e_pent1m = {1'b1, 1'b1, 1'b0, 6'h33}; // page is 7..5 over 2..0
		io_wr(16'h7FFD, 8'hD3, 1'b1);
		e_peff7  = 8'h81; // 1m lock hides 6, 3, 2, 1
		e_p7ffd  = 8'h13; // and p7ffd 7..5
		e_pent1m = {1'b1, 1'b0, 1'b1, 6'h33};
		io_wr(16'hEFF7, 8'hCF, 1'b1);
		io_wr(16'hFFF7, 8'hFF, 1'b1); // a12 high, not EFF7
		e_p7ffd  = 8'h00;
		e_pent1m = {1'b0, 1'b0, 1'b1, 6'h08};
		io_wr(16'h7FFD, 8'h20, 1'b1); // block48k set
		io_wr(16'h7FFD, 8'h17, 1'b1); // both locks, ignored
		e_peff7  = 8'h00;
		e_p7ffd  = 8'h20;
		e_pent1m = {1'b0, 1'b1, 1'b0, 6'h08};
		io_wr(16'hEFF7, 8'h00, 1'b1);
		e_p7ffd  = 8'h15;
		e_pent1m = {1'b1, 1'b1, 1'b0, 6'h05};
		io_wr(16'h7FFD, 8'h15, 1'b1);

		// border and beeper
		d = pick_byte();
		e_border = {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0};
		e_psd    = {{8{d[3]}}, d[4], {7{d[3]}}, {8{d[4]}}, {8{d[4]}}};
		io_wr(16'h00FE, d, 1'b1);

		// covox on both ports
		d = pick_byte();
		e_psd = {4{d}};
		io_wr(16'h00FB, d, 1'b1);
		d = pick_byte();
		e_psd = {4{d}};
		io_wr(16'h00DD, d, 1'b1);

		// soundrive, one channel each
		d = pick_byte();
		e_psd[7:0] = d;
		io_wr(16'h000F, d, 1'b1);
		d = pick_byte();
		e_psd[15:8] = d;
		io_wr(16'h001F, d, 1'b1);
		d = pick_byte();
		e_psd[23:16] = d;
		io_wr(16'h004F, d, 1'b1);
		d = pick_byte();
		e_psd[31:24] = d;
		io_wr(16'h005F, d, 1'b1);

		// shadow mode hides soundrive, joystick and EFF7
		e_romrw = 1'b1;
		io_wr(16'h00BF, 8'h03, 1'b1);
		io_wr(16'h000F, pick_byte(), 1'b0);
		io_wr(16'h001F, pick_byte(), 1'b0);
		io_wr(16'h004F, pick_byte(), 1'b0);
		io_wr(16'h005F, pick_byte(), 1'b0);
		io_wr(16'hEFF7, 8'h04, 1'b0);
		io_rd(16'h001F, 1'b0, `ZP_IDLE_DATA, 1'b0);
		e_romrw = 1'b0;
		io_wr(16'h00BF, 8'h00, 1'b1);
		io_rd(16'h001F, 1'b1, `ZP_IDLE_DATA, 1'b0); // dos alone also shadows

		// reads and AY control
		io_rd(16'h00FE, 1'b0, {1'b1, tape_read, 1'b0, keys_in}, 1'b1);
		io_rd(16'h001F, 1'b0, {3'b000, kj_in}, 1'b1);
		io_rd(16'h00DF, 1'b0, mus_in, 1'b1);
		io_rd(16'h003B, 1'b0, `ZP_IDLE_DATA, 1'b0);
		io_rd(16'hFFFD, 1'b0, `ZP_IDLE_DATA, 1'b1);
		io_wr(16'hFFFD, pick_byte(), 1'b1); // a15 high, p7ffd kept
		io_rd(16'hBFFD, 1'b0, `ZP_IDLE_DATA, 1'b1);
		io_wr(16'hBFFD, pick_byte(), 1'b1);

		// ide, normal order
		w1 = new_word();
		w2 = new_word();
		ide_rd(16'h0010, w1, w1[7:0], 1'b0);
		ide_rd(16'h0011, w2, w1[15:8], 1'b1); // high byte from the staged word
		hi = pick_byte();
		lo = pick_byte();
		ide_wr(16'h0011, hi, 1'b1, 16'h0000, 1'b0);
		ide_wr(16'h0010, lo, 1'b0, {hi, lo}, 1'b1);

		// ide, divide order
		w1 = new_word();
		w2 = new_word();
		ide_rd(16'h0010, w1, w1[7:0], 1'b0);
		ide_rd(16'h0010, w2, w1[15:8], 1'b1);
		lo = pick_byte();
		hi = pick_byte();
		ide_wr(16'h0010, lo, 1'b1, 16'h0000, 1'b0);
		ide_wr(16'h0010, hi, 1'b0, {hi, lo}, 1'b1);

		w1 = new_word();
		ide_rd(16'h00F0, w1, w1[7:0], 1'b0); // task file register
		w2 = new_word();
		ide_rd(16'h00C8, w2, w2[7:0], 1'b0); // second chip select
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus cycle: 3 clocks active, 2 idle

	task automatic run_entry(input int idx);
		cur_ent = idx;
		a       = t_addr[idx];
		din     = t_din[idx];
		dos     = t_dos[idx];
		idein   = t_idein[idx];
		iorq_n  = 1'b0;
		if (t_wr[idx])
			wr_n = 1'b0;
		else
			rd_n = 1'b0;
		repeat (2) @(posedge zclk);
		@(negedge zclk); // strobe edge has passed
		if (!t_wr[idx])
			check("dout", dout, t_dout[idx]);
		check("porthit", porthit, t_hit[idx]);
		check("dataout", dataout, t_dataout[idx]);
		check("ay_bc1", ay_bc1, t_bc1[idx]);
		check("ay_bdir", ay_bdir, t_bdir[idx]);
		check("ide_rd_n", ide_rd_n, t_rd_n[idx]);
		check("ide_wr_n", ide_wr_n, t_wr_n[idx]);
		check("idedataout", idedataout, t_rd_n[idx]); // released only for a drive read
		check("ide_a", ide_a, t_ide_a[idx]);
		check("ide_cs0_n", ide_cs0_n, t_cs0_n[idx]);
		check("ide_cs1_n", ide_cs1_n, t_cs1_n[idx]);
		if (t_chk_io[idx])
			check("ideout", ideout, t_ideout[idx]);
		@(posedge zclk);
		#1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(posedge zclk);
		#1;
		check("p7ffd", p7ffd, t_p7ffd[idx]);
		check("peff7", peff7, t_peff7[idx]);
		check("border", border, t_border[idx]);
		check("psd0", psd0, t_psd[idx][7:0]);
		check("psd1", psd1, t_psd[idx][15:8]);
		check("psd2", psd2, t_psd[idx][23:16]);
		check("psd3", psd3, t_psd[idx][31:24]);
		check("romrw_en", romrw_en, t_romrw[idx]);
		check("pent1m_rom", pent1m_rom, t_pent1m[idx][8]);
		check("pent1m_1m_on", pent1m_1m_on, t_pent1m[idx][7]);
		check("pent1m_ram0_0", pent1m_ram0_0, t_pent1m[idx][6]);
		check("pent1m_page", pent1m_page, t_pent1m[idx][5:0]);
	endtask

	task automatic check_reset();
		check("p7ffd", p7ffd, {3'b000, rstrom[0], 4'b0000});
		check("peff7", peff7, 8'h00);
		check("border", border, 6'h00);
		check("psd0", psd0, 8'h00);
		check("psd1", psd1, 8'h00);
		check("psd2", psd2, 8'h00);
		check("psd3", psd3, 8'h00);
		check("romrw_en", romrw_en, 1'b0);
		check("pent1m_1m_on", pent1m_1m_on, 1'b1);
		check("pent1m_ram0_0", pent1m_ram0_0, 1'b0);
		check("pent1m_page", pent1m_page, 6'h00);
		check("ide_rd_n", ide_rd_n, 1'b1);
		check("ide_wr_n", ide_wr_n, 1'b1);
		check("idedataout", idedataout, 1'b1);
	endtask

	initial
	begin
		wait (table_done);
		#((n_ent * 6 + RST_CYCLES + 20) * CLK_PERIOD);
		$display("timeout: the bus table did not complete in the allotted time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		logic [15:0] w;
		int          i;

		seed_v     = $urandom(SEED);
		table_done = 1'b0;
		n_err      = 0;
		n_checks   = 0;
		cur_ent    = -1; // before the table
		rst_n      = 1'b0;
		rstrom     = 2'b01;
		a          = 16'h0000;
		din        = 8'h00;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		idein      = 16'h0000;
		dos        = 1'b0;
		w          = new_word();
		keys_in    = w[4:0];
		kj_in      = w[9:5];
		tape_read  = w[10];
		mus_in     = pick_byte();

		build_table();
		table_done = 1'b1;

		repeat (RST_CYCLES) @(posedge zclk);
		#1;
		rst_n = 1'b1;
		check_reset();
		@(posedge zclk);
		#1;
		for (i = 0; i < n_ent; i++)
			run_entry(i);

		$display("checks: %0d, errors: %0d", n_checks, n_err);
		if (n_err == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
zports_pkg.sv
port_strobe.sv
port_decode.sv
mem_config_regs.sv
sound_border.sv
ide_bridge.sv
zports.sv
tb_zports.sv

/* Bender.yml */
package:
  name: zports

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - zports_pkg.sv
      - port_strobe.sv
      - port_decode.sv
      - mem_config_regs.sv
      - sound_border.sv
      - ide_bridge.sv
      - zports.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_zports.sv
